// File: logic/commit_map_table.sv
// Committed register map: two commit writes, paired restore reads, identity at reset
`timescale 1ns/10ps
`default_nettype none

module commit_map_table
    import retire_pkg::*;
(
    input  wire logic       cpu_clock_i,
    input  wire logic       rst_n_i,
    input  wire map_write_t map_wr0_i,
    input  wire map_write_t map_wr1_i,
    input  wire areg_t      recover_index_i,
    output restore_pair_t   restore_o
);

    localparam int NUM_AREGS = 32;

    preg_t crmt [NUM_AREGS];
    areg_t restore_idx1;

    // Odd partner of the even recover index
    assign restore_idx1 = {recover_index_i[4:1], 1'b1};

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                crmt[i] <= preg_t'(i);
            end
        end else begin
            if (map_wr0_i.valid && map_wr0_i.arch_reg != '0) begin
                crmt[map_wr0_i.arch_reg] <= map_wr0_i.preg;
            end
            // Younger slot, so it overrides slot 0 on the same register
            if (map_wr1_i.valid && map_wr1_i.arch_reg != '0) begin
                crmt[map_wr1_i.arch_reg] <= map_wr1_i.preg;
            end
        end
    end

    always_comb begin
        restore_o.arch0 = recover_index_i;
        restore_o.preg0 = crmt[recover_index_i];
        restore_o.arch1 = restore_idx1;
        restore_o.preg1 = crmt[restore_idx1];
    end

endmodule

`default_nettype wire

// File: logic/retire_control_unit.sv
// Retire control unit top: packet buffer, committed map and sequencer
`timescale 1ns/10ps
`default_nettype none

module retire_control_unit
    import retire_pkg::*;
#(
    parameter int BUF_DEPTH_LOG2 = BUF_DEPTH_LOG2_DEF
) (
    input  wire logic           cpu_clock_i,
    input  wire logic           rst_n_i,
    // Rename
    input  wire logic           push_i,
    input  wire retire_packet_t packet_i,
    output logic                rcu_busy_o,
    output buf_ptr_t            rcu_pack_o,     // ROB id base of the next packet
    // ROB
    output rob_id_t             rob_head_id_o,
    input  wire logic           rob_done0_i,
    input  wire logic           rob_done1_i,
    // Free list
    output free_req_t           free0_o,
    output free_req_t           free1_o,
    // Trap and redirect
    input  wire logic [31:0]    mtvec_i,
    output logic                take_exception_o,
    output pc_t                 epc_o,
    output excp_code_t          mcause_o,
    output logic                flush_o,
    output pc_t                 flush_address_o,
    output restore_pair_t       restore_o
);

    retire_packet_t head;
    logic           empty;
    buf_ptr_t       rd_ptr;
    logic           pop;
    map_write_t     map_wr0;
    map_write_t     map_wr1;
    areg_t          recover_index;

    retire_packet_buffer #(
        .BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
    ) packet_buffer (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push_i && !flush_o),  // No new work while draining
        .packet_i    (packet_i),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (empty),
        .full_o      (rcu_busy_o),
        .rd_ptr_o    (rd_ptr),
        .wr_ptr_o    (rcu_pack_o)
    );

    commit_map_table commit_map (
        .cpu_clock_i     (cpu_clock_i),
        .rst_n_i         (rst_n_i),
        .map_wr0_i       (map_wr0),
        .map_wr1_i       (map_wr1),
        .recover_index_i (recover_index),
        .restore_o       (restore_o)
    );

    retire_sequencer #(
        .BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
    ) sequencer (
        .cpu_clock_i      (cpu_clock_i),
        .rst_n_i          (rst_n_i),
        .head_i           (head),
        .empty_i          (empty),
        .rd_ptr_i         (rd_ptr),
        .rob_done0_i      (rob_done0_i),
        .rob_done1_i      (rob_done1_i),
        .mtvec_i          (mtvec_i),
        .pop_o            (pop),
        .map_wr0_o        (map_wr0),
        .map_wr1_o        (map_wr1),
        .recover_index_o  (recover_index),
        .rob_head_id_o    (rob_head_id_o),
        .free0_o          (free0_o),
        .free1_o          (free1_o),
        .take_exception_o (take_exception_o),
        .epc_o            (epc_o),
        .mcause_o         (mcause_o),
        .flush_o          (flush_o),
        .flush_address_o  (flush_address_o)
    );

endmodule

`default_nettype wire

// File: logic/retire_packet_buffer.sv
// Retire packet buffer: circular packet store with wrap-bit head and tail pointers
`timescale 1ns/10ps
`default_nettype none

module retire_packet_buffer
    import retire_pkg::*;
#(
    parameter int BUF_DEPTH_LOG2 = BUF_DEPTH_LOG2_DEF
) (
    input  wire logic           cpu_clock_i,
    input  wire logic           rst_n_i,
    input  wire logic           push_i,
    input  wire retire_packet_t packet_i,
    input  wire logic           pop_i,
    output retire_packet_t      head_o,
    output logic                empty_o,
    output logic                full_o,
    output buf_ptr_t            rd_ptr_o,
    output buf_ptr_t            wr_ptr_o
);

    localparam int DEPTH = 2 ** BUF_DEPTH_LOG2;

    retire_packet_t packets [DEPTH];
    buf_ptr_t       rd_ptr;
    buf_ptr_t       wr_ptr;
    logic           do_push;
    logic           do_pop;

    // Same slot; wrap bits tell empty from full
    assign empty_o = (rd_ptr[BUF_DEPTH_LOG2:0] == wr_ptr[BUF_DEPTH_LOG2:0]);
    assign full_o  = (rd_ptr[BUF_DEPTH_LOG2] != wr_ptr[BUF_DEPTH_LOG2])
                  && (rd_ptr[BUF_DEPTH_LOG2-1:0] == wr_ptr[BUF_DEPTH_LOG2-1:0]);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge cpu_clock_i) begin
        if (do_push) begin
            packets[wr_ptr[BUF_DEPTH_LOG2-1:0]] <= packet_i;
        end
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + buf_ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + buf_ptr_t'(1);
            end
        end
    end

    assign head_o   = packets[rd_ptr[BUF_DEPTH_LOG2-1:0]];  // Shown without a read cycle
    assign rd_ptr_o = rd_ptr;
    assign wr_ptr_o = wr_ptr;

endmodule

`default_nettype wire

// File: logic/retire_pkg.sv
// Retire types: register, ROB, pointer and PC widths, packet structs, retire state enum
`default_nettype none

package retire_pkg;

    localparam int BUF_DEPTH_LOG2_DEF = 4;

    typedef logic [4:0]  areg_t;
    typedef logic [5:0]  preg_t;
    typedef logic [4:0]  rob_id_t;      // Buffer slot, then instruction slot
    typedef logic [4:0]  buf_ptr_t;     // Wrap bit on top
    typedef logic [29:0] pc_t;          // Word address
    typedef logic [3:0]  excp_code_t;

    typedef struct packed {
        logic       allocated;
        areg_t      arch_reg;
        preg_t      old_preg;
        preg_t      new_preg;
        logic       excp_valid;
        excp_code_t excp_code;
    } retire_ins_t;

    typedef struct packed {
        pc_t         pc;
        retire_ins_t ins0;
        retire_ins_t ins1;
        logic        ins1_valid;
    } retire_packet_t;

    // Toward the free list
    typedef struct packed {
        logic  valid;
        preg_t preg;
    } free_req_t;

    typedef struct packed {
        logic  valid;
        areg_t arch_reg;
        preg_t preg;
    } map_write_t;

    // Two committed mappings per flush cycle for rename
    typedef struct packed {
        areg_t arch0;
        preg_t preg0;
        areg_t arch1;
        preg_t preg1;
    } restore_pair_t;

    typedef enum logic {
        RS_NORMAL,
        RS_RECOVER
    } retire_state_t;

endpackage

`default_nettype wire

// File: logic/retire_sequencer.sv
// Retire sequencer: commit and partial retire, register release, exception entry, recovery FSM
`timescale 1ns/10ps
`default_nettype none

module retire_sequencer
    import retire_pkg::*;
#(
    parameter int BUF_DEPTH_LOG2 = BUF_DEPTH_LOG2_DEF
) (
    input  wire logic           cpu_clock_i,
    input  wire logic           rst_n_i,
    // Buffer head
    input  wire retire_packet_t head_i,
    input  wire logic           empty_i,
    input  wire buf_ptr_t       rd_ptr_i,
    // ROB and trap logic
    input  wire logic           rob_done0_i,
    input  wire logic           rob_done1_i,
    input  wire logic [31:0]    mtvec_i,
    output logic                pop_o,
    // Committed map
    output map_write_t          map_wr0_o,
    output map_write_t          map_wr1_o,
    output areg_t               recover_index_o,
    // Outward
    output rob_id_t             rob_head_id_o,
    output free_req_t           free0_o,
    output free_req_t           free1_o,
    output logic                take_exception_o,
    output pc_t                 epc_o,
    output excp_code_t          mcause_o,
    output logic                flush_o,
    output pc_t                 flush_address_o
);

    // One recover step per buffer slot, two map entries each
    localparam areg_t LAST_RECOVER_INDEX = areg_t'(2 * (2 ** BUF_DEPTH_LOG2 - 1));

    retire_state_t state;
    logic          partial_retire;  // Slot 0 of the head already gone
    areg_t         recover_index;
    logic          in_recover;
    logic          head_valid;
    logic          commit0;
    logic          commit1;
    logic          excp0;
    logic          excp1;
    logic          reclaim0;
    logic          reclaim1;

    assign in_recover = (state == RS_RECOVER);
    assign head_valid = (state == RS_NORMAL) && !empty_i;

    assign rob_head_id_o = rob_id_t'({rd_ptr_i[BUF_DEPTH_LOG2-1:0], 1'b0});

    assign commit0 = head_valid && !partial_retire && rob_done0_i
                  && !head_i.ins0.excp_valid;
    assign commit1 = head_valid && (commit0 || partial_retire) && head_i.ins1_valid
                  && rob_done1_i && !head_i.ins1.excp_valid;

    // Oldest uncommitted slot carrying an exception
    assign excp0 = head_valid && !partial_retire && head_i.ins0.excp_valid;
    assign excp1 = head_valid && (commit0 || partial_retire) && head_i.ins1_valid
                && head_i.ins1.excp_valid;

    assign take_exception_o = excp0 || excp1;
    assign epc_o            = excp1 ? head_i.pc + pc_t'(1) : head_i.pc;
    assign mcause_o         = excp1 ? head_i.ins1.excp_code : head_i.ins0.excp_code;

    // Squashed instructions give back their new registers
    assign reclaim0 = in_recover && !empty_i && !partial_retire && head_i.ins0.allocated;
    assign reclaim1 = in_recover && !empty_i && head_i.ins1_valid && head_i.ins1.allocated;

    assign pop_o = in_recover ? !empty_i
                 : (commit0 && (!head_i.ins1_valid || commit1)) || (partial_retire && commit1);

    always_comb begin
        free0_o.valid = in_recover ? reclaim0
                      : commit0 && head_i.ins0.allocated && (head_i.ins0.old_preg != '0);
        free0_o.preg  = in_recover ? head_i.ins0.new_preg : head_i.ins0.old_preg;
        free1_o.valid = in_recover ? reclaim1
                      : commit1 && head_i.ins1.allocated && (head_i.ins1.old_preg != '0);
        free1_o.preg  = in_recover ? head_i.ins1.new_preg : head_i.ins1.old_preg;
    end

    always_comb begin
        map_wr0_o.valid    = commit0 && head_i.ins0.allocated;
        map_wr0_o.arch_reg = head_i.ins0.arch_reg;
        map_wr0_o.preg     = head_i.ins0.new_preg;
        map_wr1_o.valid    = commit1 && head_i.ins1.allocated;
        map_wr1_o.arch_reg = head_i.ins1.arch_reg;
        map_wr1_o.preg     = head_i.ins1.new_preg;
    end

    always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state          <= RS_NORMAL;
            partial_retire <= 1'b0;
            recover_index  <= '0;
        end else begin
            case (state)
                RS_NORMAL: begin
                    if (partial_retire) begin
                        partial_retire <= !commit1;
                    end else begin
                        partial_retire <= commit0 && head_i.ins1_valid && !commit1;
                    end
                    if (take_exception_o) begin
                        state <= RS_RECOVER;
                    end
                end
                RS_RECOVER: begin
                    // Excepting packet leaves first, later ones are whole
                    partial_retire <= 1'b0;
                    recover_index  <= recover_index + areg_t'(2);  // Wraps to 0 on exit
                    if (recover_index == LAST_RECOVER_INDEX) begin
                        state <= RS_NORMAL;
                    end
                end
                default: begin
                    state <= RS_NORMAL;
                end
            endcase
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (take_exception_o) begin
            flush_address_o <= mtvec_i[31:2];  // Direct mode vector
        end
    end

    assign flush_o         = in_recover;
    assign recover_index_o = recover_index;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the retire control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module retire_tb -Mdir obj_dir -f vlog.f

output=$(./obj_dir/Vretire_tb) || true
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// File: tb/retire_assertions.sv
// Retire sequencer assertions: flush length, exception outside flush, no release of register 0
`timescale 1ns/10ps
`default_nettype none

module retire_assertions
    import retire_pkg::*;
(
    input  wire logic      cpu_clock_i,
    input  wire logic      rst_n_i,
    input  wire logic      flush_o,
    input  wire logic      take_exception_o,
    input  wire free_req_t free0_o,
    input  wire free_req_t free1_o
);

    localparam int FLUSH_CYCLES = 2 ** BUF_DEPTH_LOG2_DEF;

    // Flush ends exactly one recovery length after it starts
    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        $rose(flush_o) |-> ##FLUSH_CYCLES $fell(flush_o))
        else $error("flush_o did not fall after %0d cycles", FLUSH_CYCLES);

    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        $fell(flush_o) |-> $past(flush_o, FLUSH_CYCLES))
        else $error("flush_o fell before %0d cycles", FLUSH_CYCLES);

    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        !(take_exception_o && flush_o))
        else $error("take_exception_o while flush_o is high");

    // Register 0 is never handed back on commit
    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        (!flush_o && free0_o.valid) |-> (free0_o.preg != '0))
        else $error("free0_o released register 0");

    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        (!flush_o && free1_o.valid) |-> (free1_o.preg != '0))
        else $error("free1_o released register 0");

endmodule

bind retire_sequencer retire_assertions seq_assertions (
    .cpu_clock_i      (cpu_clock_i),
    .rst_n_i          (rst_n_i),
    .flush_o          (flush_o),
    .take_exception_o (take_exception_o),
    .free0_o          (free0_o),
    .free1_o          (free1_o)
);

`default_nettype wire

// File: tb/retire_tb.sv
// Retire control unit testbench: vector reader, ROB completion model, reference model, watchdog
`timescale 1ns/10ps
`default_nettype none

module retire_tb
    import retire_pkg::*;
();

    localparam logic [31:0] MTVEC         = 32'h0000_0f40;
    localparam int          NUM_VEC_WORDS = 512;
    localparam int          SLOW_DELAY    = 40;
    localparam int          FLUSH_CYCLES  = 2 ** BUF_DEPTH_LOG2_DEF;
    localparam int          NOT_READY     = 32'h7fff_ffff;

    typedef struct packed {
        retire_ins_t ins;
        pc_t         pc;
        logic        slot;
        logic        slot1_late;    // Slot 1 of this packet completes late
    } model_ins_t;

    logic           cpu_clock_i;
    logic           rst_n_i = 1'b0;
    logic           push_i = 1'b0;
    retire_packet_t packet_i = '0;
    logic           rob_done0_i = 1'b0;
    logic           rob_done1_i = 1'b0;
    logic [31:0]    mtvec_i = MTVEC;
    logic           rcu_busy_o;
    buf_ptr_t       rcu_pack_o;
    rob_id_t        rob_head_id_o;
    free_req_t      free0_o;
    free_req_t      free1_o;
    logic           take_exception_o;
    pc_t            epc_o;
    excp_code_t     mcause_o;
    logic           flush_o;
    pc_t            flush_address_o;
    restore_pair_t  restore_o;

    logic [35:0] vec_mem [NUM_VEC_WORDS];
    int          n_records = 0;
    int          mismatches = 0;
    int          failures = 0;
    int          cycle = 0;
    int          ready_at [32];     // Cycle from which each ROB id reports done
    logic        hold = 1'b0;
    int          held_count = 0;
    int          flush_count = 0;
    logic [31:0] rng_state = 32'hc758ae16;
    buf_ptr_t    exp_wr_ptr = '0;
    pc_t         exp_flush_address = '0;
    model_ins_t  iq [$];            // Pushed, not yet retired, in program order
    preg_t       reclaim_q [$];
    pc_t         exp_epc_q [$];
    excp_code_t  exp_cause_q [$];
    preg_t       ref_map [32];

    retire_control_unit dut0 (
        .cpu_clock_i      (cpu_clock_i),
        .rst_n_i          (rst_n_i),
        .push_i           (push_i),
        .packet_i         (packet_i),
        .rcu_busy_o       (rcu_busy_o),
        .rcu_pack_o       (rcu_pack_o),
        .rob_head_id_o    (rob_head_id_o),
        .rob_done0_i      (rob_done0_i),
        .rob_done1_i      (rob_done1_i),
        .free0_o          (free0_o),
        .free1_o          (free1_o),
        .mtvec_i          (mtvec_i),
        .take_exception_o (take_exception_o),
        .epc_o            (epc_o),
        .mcause_o         (mcause_o),
        .flush_o          (flush_o),
        .flush_address_o  (flush_address_o),
        .restore_o        (restore_o)
    );

    initial begin
        cpu_clock_i = 1'b0;
        forever #50 cpu_clock_i = ~cpu_clock_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Token digits: alloc, arch(2), old(2), new(2), excp, code
    function automatic retire_ins_t decode_slot(input logic [35:0] t);
        retire_ins_t ins;
        ins.allocated  = t[32];
        ins.arch_reg   = t[28:24];
        ins.old_preg   = t[21:16];
        ins.new_preg   = t[13:8];
        ins.excp_valid = t[4];
        ins.excp_code  = t[3:0];
        return ins;
    endfunction

    function automatic logic frees_old(input model_ins_t e);
        return e.ins.allocated && (e.ins.old_preg != '0);
    endfunction

    task automatic check_preg(input string name, input preg_t exp, input preg_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_code(input string name, input excp_code_t exp, input excp_code_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_restore(input string name, input restore_pair_t exp,
                                 input restore_pair_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_ptr(input string name, input buf_ptr_t exp, input buf_ptr_t act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic apply_commit(input model_ins_t e);
        if (e.ins.allocated && e.ins.arch_reg != '0) begin
            ref_map[e.ins.arch_reg] = e.ins.new_preg;
        end
    endtask

    // Retire up to the next instruction that frees its old register
    task automatic retire_next(input string name, input preg_t act);
        model_ins_t e;
        logic       matched;
        matched = 1'b0;
        while (!matched) begin
            if (iq.size() == 0) begin
                report_failure({name, " released a register with no instruction pending"});
                matched = 1'b1;
            end else begin
                e = iq.pop_front();
                if (e.ins.excp_valid) begin
                    report_failure({name, " released past an excepting instruction"});
                end
                apply_commit(e);
                if (frees_old(e)) begin
                    check_preg(name, e.ins.old_preg, act);
                    // Slot 0 goes ahead of its late partner
                    if (e.slot1_late) begin
                        check_flag("rob_done1_i at partial retire", 1'b0, rob_done1_i);
                    end
                    matched = 1'b1;
                end
            end
        end
    endtask

    task automatic enter_exception();
        model_ins_t e;
        while (iq.size() > 0 && !iq[0].ins.excp_valid) begin
            e = iq.pop_front();
            if (frees_old(e)) begin
                report_failure("instruction before the exception committed without release");
            end
            apply_commit(e);
        end
        if (iq.size() == 0) begin
            report_failure("exception taken with no excepting instruction pending");
        end else if (exp_epc_q.size() == 0) begin
            report_failure("exception taken that no vector expects");
        end else begin
            if (iq[0].pc + pc_t'(iq[0].slot) != exp_epc_q[0]) begin
                report_failure("vector trap PC disagrees with the excepting instruction");
            end
            check_pc("epc_o", exp_epc_q.pop_front(), epc_o);
            check_code("mcause_o", exp_cause_q.pop_front(), mcause_o);
        end
        foreach (iq[i]) begin
            if (iq[i].ins.allocated) begin
                reclaim_q.push_back(iq[i].ins.new_preg);
            end
        end
        iq.delete();
    endtask

    task automatic reclaim_check(input string name, input preg_t act);
        if (reclaim_q.size() == 0) begin
            report_failure({name, " reclaimed a register during flush that was not squashed"});
        end else begin
            check_preg(name, reclaim_q.pop_front(), act);
        end
    endtask

    task automatic push_packet(input retire_packet_t pkt, input logic slow1);
        logic    accept;
        rob_id_t base_id;
        int      delay0;
        int      delay1;
        @(posedge cpu_clock_i);
        push_i   <= 1'b1;
        packet_i <= pkt;
        @(posedge cpu_clock_i);
        push_i <= 1'b0;
        check_ptr("rcu_pack_o", exp_wr_ptr, rcu_pack_o);
        accept = !hold || (held_count < FLUSH_CYCLES);
        if (hold) begin
            check_flag("rcu_busy_o", !accept, rcu_busy_o);
        end
        if (accept) begin
            if (hold) begin
                held_count++;
            end
            base_id    = rob_id_t'({exp_wr_ptr[3:0], 1'b0});
            exp_wr_ptr = exp_wr_ptr + buf_ptr_t'(1);
            rng_state  = xorshift32(rng_state);
            delay0     = int'(rng_state % 32'd8) + 1;
            rng_state  = xorshift32(rng_state);
            delay1     = slow1 ? SLOW_DELAY : int'(rng_state % 32'd8) + 1;
            ready_at[base_id]                 = cycle + delay0;
            ready_at[base_id + rob_id_t'(1)] = cycle + delay1;
            iq.push_back(model_ins_t'{pkt.ins0, pkt.pc, 1'b0, slow1});
            if (pkt.ins1_valid) begin
                iq.push_back(model_ins_t'{pkt.ins1, pkt.pc, 1'b1, 1'b0});
            end
        end
    endtask

    // Wait for an empty buffer outside flush, then retire silent leftovers
    task automatic drain_and_settle();
        model_ins_t e;
        do @(posedge cpu_clock_i);
        while (flush_o || rcu_busy_o || rob_head_id_o != rob_id_t'({exp_wr_ptr[3:0], 1'b0}));
        while (iq.size() > 0) begin
            e = iq.pop_front();
            if (frees_old(e)) begin
                report_failure("a committed instruction never released its old register");
            end
            apply_commit(e);
        end
    endtask

    // ROB model, answers for the head as it stands after this edge
    always @(posedge cpu_clock_i) begin
        rob_id_t next_head;
        rob_id_t next_second;
        next_head   = rob_head_id_o + (dut0.pop ? rob_id_t'(2) : rob_id_t'(0));
        next_second = next_head + rob_id_t'(1);
        if (dut0.pop) begin
            ready_at[rob_head_id_o]                 = NOT_READY;  // Id free for reuse
            ready_at[rob_head_id_o + rob_id_t'(1)] = NOT_READY;
        end
        cycle       <= cycle + 1;
        rob_done0_i <= !hold && (cycle >= ready_at[next_head]);
        rob_done1_i <= !hold && (cycle >= ready_at[next_second]);
    end

    always @(posedge cpu_clock_i) begin
        restore_pair_t exp_pair;
        if (rst_n_i) begin
            if (flush_o) begin
                exp_pair.arch0 = areg_t'(2 * flush_count);
                exp_pair.preg0 = ref_map[2 * flush_count];
                exp_pair.arch1 = areg_t'(2 * flush_count + 1);
                exp_pair.preg1 = ref_map[2 * flush_count + 1];
                check_restore("restore_o", exp_pair, restore_o);
                check_pc("flush_address_o", exp_flush_address, flush_address_o);
                if (free0_o.valid) begin
                    reclaim_check("free0_o", free0_o.preg);
                end
                if (free1_o.valid) begin
                    reclaim_check("free1_o", free1_o.preg);
                end
                flush_count++;
                if (flush_count == FLUSH_CYCLES) begin
                    flush_count = 0;
                    if (reclaim_q.size() != 0) begin
                        report_failure("flush ended before all squashed registers came back");
                    end
                    reclaim_q.delete();
                end
            end else begin
                if (free0_o.valid) begin
                    retire_next("free0_o", free0_o.preg);
                end
                if (free1_o.valid) begin
                    retire_next("free1_o", free1_o.preg);
                end
                if (take_exception_o) begin
                    exp_flush_address = mtvec_i[31:2];
                    mtvec_i <= mtvec_i + 32'h0000_0100;  // Latched vector must not follow
                    enter_exception();  // After the frees of its own cycle
                end
            end
        end
    end

    initial begin
        int             r;
        logic [3:0]     kind;
        retire_packet_t pkt;
        for (int i = 0; i < 32; i++) begin
            ready_at[i] = NOT_READY;
            ref_map[i]  = preg_t'(i);
        end
        $readmemh("tb/retire_vectors.txt", vec_mem);
        r = 0;
        while (vec_mem[5 * r][3:0] != 4'h0) begin
            r++;
        end
        n_records = r + 1;
        repeat (16) @(posedge cpu_clock_i);
        rst_n_i <= 1'b1;
        for (r = 0; r < n_records - 1; r++) begin
            kind           = vec_mem[5 * r][3:0];
            pkt.pc         = vec_mem[5 * r + 1][29:0];
            pkt.ins0       = decode_slot(vec_mem[5 * r + 2]);
            pkt.ins1       = decode_slot(vec_mem[5 * r + 3]);
            pkt.ins1_valid = vec_mem[5 * r + 4][0];
            case (kind)
                4'h1: push_packet(pkt, 1'b0);
                4'h2: push_packet(pkt, 1'b1);
                4'h3: begin
                    hold       <= 1'b1;
                    held_count = 0;
                end
                4'h4: hold <= 1'b0;
                4'h5: begin
                    exp_epc_q.push_back(pkt.pc);
                    exp_cause_q.push_back(vec_mem[5 * r + 2][3:0]);
                end
                4'h6: drain_and_settle();
                default: report_failure("unknown record kind in the vector file");
            endcase
        end
        drain_and_settle();
        if (exp_epc_q.size() != 0) begin
            report_failure("an expected exception was never taken");
        end
        $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (n_records > 0);
        repeat (40 * n_records + 100) @(posedge cpu_clock_i);
        $display("Timeout: the run did not finish within %0d cycles", 40 * n_records + 100);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/retire_vectors.txt
// kind pc slot0 slot1 ins1_valid; kinds 1 push, 2 push slow slot1, 3 hold, 4 release, 5 trap, 6 drain, 0 end
// slot digits: alloc arch(2) old(2) new(2) excp code; trap record has epc in pc, cause in slot0
1 00001000 101012000 102022100 1
1 00001002 103032200 000000000 0
1 00001004 000000000 105042400 1
1 00001006 106002500 107052600 1
6 0 0 0 0
2 00001010 10c0a2b00 10d0b2c00 1
1 00001012 10e0c2d00 10f0d2e00 1
6 0 0 0 0
3 0 0 0 0
1 00002000 101102000 000000000 0
1 00002002 102112100 000000000 0
1 00002004 103122200 000000000 0
1 00002006 104132300 000000000 0
1 00002008 105142400 000000000 0
1 0000200a 106152500 000000000 0
1 0000200c 107162600 000000000 0
1 0000200e 108172700 000000000 0
1 00002010 109182800 000000000 0
1 00002012 10a192900 000000000 0
1 00002014 10b1a2a00 000000000 0
1 00002016 10c1b2b00 000000000 0
1 00002018 10d1c2c00 000000000 0
1 0000201a 10e1d2d00 000000000 0
1 0000201c 10f1e2e00 000000000 0
1 0000201e 1101f2f00 000000000 0
1 00002020 111203000 000000000 0
4 0 0 0 0
6 0 0 0 0
5 00003003 000000002 000000000 0
3 0 0 0 0
1 00003000 112213100 113223200 1
1 00003002 114233300 115243412 1
1 00003004 116253500 117263600 1
4 0 0 0 0
6 0 0 0 0
1 00003010 118273700 119283800 1
1 00003012 000000000 11a293900 1
6 0 0 0 0
5 00003020 000000005 000000000 0
1 00003020 11b2a3a15 11c2b3b00 1
6 0 0 0 0
0 0 0 0 0

// File: vlog.f
logic/retire_pkg.sv
logic/retire_packet_buffer.sv
logic/commit_map_table.sv
logic/retire_sequencer.sv
logic/retire_control_unit.sv
tb/retire_assertions.sv
tb/retire_tb.sv
